/* hdl/mul_pkg.sv */
// Shared types and widths for the RV32M multiply unit; width is fixed at 32 bits by the ISA
package mul_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data path width of the integer register file
  localparam int XLEN   = 32;

  // Operand half used by the high-word state machine
  localparam int HALF_W = 16;

  // Accumulator for partial products
  // One bit wider than a word so signed cross-product sums fit
  localparam int ACC_W  = 33;

  ////////////////////
  // Request function
  ////////////////////

  // Function code presented at the top-level request port
  typedef enum logic [1:0] {
    FUNCT_MUL    = 2'b00,
    FUNCT_MULH   = 2'b01,
    FUNCT_MULHSU = 2'b10,
    FUNCT_MULHU  = 2'b11
  } mul_funct_e;

  ////////////////////
  // Internal operator
  ////////////////////

  // Low word in one cycle, or high word over four
  typedef enum logic {
    MUL_M32 = 1'b0,
    MUL_H   = 1'b1
  } mul_opcode_e;

  ////////////////////
  // High-word FSM
  ////////////////////

  // Named after the operand halves multiplied in that cycle
  // A = operand a, B = operand b, L = low half, H = high half
  typedef enum logic [1:0] {
    ALBL = 2'b00,
    ALBH = 2'b01,
    AHBL = 2'b10,
    AHBH = 2'b11
  } mult_state_e;

endpackage

/* hdl/mul_op_if.sv */
// One decoded multiply operation between issue buffer and core; the issue side holds it until consumed
interface mul_op_if;

  import mul_pkg::*;

  // Operation present and held stable until consumed
  logic                 enable;

  // Low-word or high-word operation
  mul_opcode_e          operator;

  // Bit 0 marks operand a signed, bit 1 marks operand b signed
  // Ignored for the low-word operation
  logic [1:0]           short_signed;

  // Operands as issued
  logic [XLEN-1:0]      op_a;
  logic [XLEN-1:0]      op_b;

  // Core presents a finished result this cycle
  logic                 ready;

  // Issue buffer side
  modport issue (
    output enable,
    output operator,
    output short_signed,
    output op_a,
    output op_b,
    input  ready
  );

  // Multiplier core side
  modport core (
    input  enable,
    input  operator,
    input  short_signed,
    input  op_a,
    input  op_b,
    output ready
  );

endinterface

/* hdl/mul_issue.sv */
// Single-entry request slot; the next request is taken only when the held one is consumed
module mul_issue (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic                     req_valid_i,
  input  mul_pkg::mul_funct_e      req_funct_i,
  input  logic [mul_pkg::XLEN-1:0] req_op_a_i,
  input  logic [mul_pkg::XLEN-1:0] req_op_b_i,
  input  logic                     ex_ready_i,
  output logic                     req_ready_o,
  mul_op_if.issue                  op
);

  import mul_pkg::*;

  // Slot state
  logic            enable_q;
  mul_opcode_e     operator_q;
  logic [1:0]      short_signed_q;
  logic [XLEN-1:0] op_a_q;
  logic [XLEN-1:0] op_b_q;

  // Decoded request
  mul_opcode_e     dec_operator;
  logic [1:0]      dec_signed;

  // Handshake terms
  logic            consume;
  logic            accept;

  ////////////////////
  // Handshake
  ////////////////////

  // Held operation leaves when core result is taken downstream
  assign consume     = enable_q & op.ready & ex_ready_i;

  // Empty slot, or slot freed this very cycle
  // Keeps back-to-back requests free of bubbles
  assign req_ready_o = ~enable_q | consume;
  assign accept      = req_valid_i & req_ready_o;

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    dec_operator = MUL_M32;
    dec_signed   = 2'b00;
    case (req_funct_i)
      FUNCT_MUL: begin
        // Signedness is irrelevant for the low word
        dec_operator = MUL_M32;
        dec_signed   = 2'b00;
      end
      FUNCT_MULH: begin
        dec_operator = MUL_H;
        dec_signed   = 2'b11;
      end
      FUNCT_MULHSU: begin
        // Signed a times unsigned b
        dec_operator = MUL_H;
        dec_signed   = 2'b01;
      end
      FUNCT_MULHU: begin
        dec_operator = MUL_H;
        dec_signed   = 2'b00;
      end
      default: begin
        dec_operator = MUL_M32;
        dec_signed   = 2'b00;
      end
    endcase
  end

  ////////////////////
  // Slot registers
  ////////////////////

  // Control part of the slot
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q       <= 1'b0;
      operator_q     <= MUL_M32;
      short_signed_q <= 2'b00;
    end else if (accept) begin
      enable_q       <= 1'b1;
      operator_q     <= dec_operator;
      short_signed_q <= dec_signed;
    end else if (consume) begin
      enable_q       <= 1'b0;
    end
  end

  // Operand payload, only loaded on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      op_a_q <= req_op_a_i;
      op_b_q <= req_op_b_i;
    end
  end

  // Drive the held operation to the core
  assign op.enable       = enable_q;
  assign op.operator     = operator_q;
  assign op.short_signed = short_signed_q;
  assign op.op_a         = op_a_q;
  assign op.op_b         = op_b_q;

endmodule

/* hdl/mul_core.sv */
// Multiply core; MUL completes in the enable cycle and the MULH family in four, and operands must stay stable until consumed
module mul_core (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic                     ex_ready_i,
  mul_op_if.core                   op,
  output logic                     res_valid_o,
  output logic [mul_pkg::XLEN-1:0] res_data_o
);

  import mul_pkg::*;

  ////////////////////
  // Declarations
  ////////////////////

  // Low word of the full product
  logic [XLEN-1:0]          mul_low;

  // High-word FSM state and accumulator
  mult_state_e              state_q;
  mult_state_e              state_d;
  logic signed [ACC_W-1:0]  acc_q;
  logic signed [ACC_W-1:0]  acc_d;

  // Selected 16-bit halves plus a sign bit each
  logic signed [HALF_W:0]   mulh_a;
  logic signed [HALF_W:0]   mulh_b;

  // Partial product plus accumulator, and its shifted form
  logic signed [ACC_W:0]    int_result;
  logic signed [ACC_W:0]    int_shift;

  // Which halves the current step uses
  logic                     a_high;
  logic                     b_high;

  logic                     mulh_active;
  logic                     ready;

  ////////////////////
  // Low word
  ////////////////////

  // Low 32 bits are the same for signed and unsigned operands
  assign mul_low = op.op_a * op.op_b;

  ////////////////////
  // Half select
  ////////////////////

  assign mulh_active = op.enable & (op.operator == MUL_H);

  // A high half in AHBL and AHBH, B high half in ALBH and AHBH
  always_comb begin
    a_high = 1'b0;
    b_high = 1'b0;
    case (state_q)
      ALBL: begin
        a_high = 1'b0;
        b_high = 1'b0;
      end
      ALBH: begin
        a_high = 1'b0;
        b_high = 1'b1;
      end
      AHBL: begin
        a_high = 1'b1;
        b_high = 1'b0;
      end
      AHBH: begin
        a_high = 1'b1;
        b_high = 1'b1;
      end
      default: begin
        a_high = 1'b0;
        b_high = 1'b0;
      end
    endcase
  end

  // Low halves are always unsigned
  // High halves take their sign from the signedness code
  assign mulh_a = a_high ? {op.short_signed[0] & op.op_a[XLEN-1], op.op_a[XLEN-1:HALF_W]}
                         : {1'b0, op.op_a[HALF_W-1:0]};
  assign mulh_b = b_high ? {op.short_signed[1] & op.op_b[XLEN-1], op.op_b[XLEN-1:HALF_W]}
                         : {1'b0, op.op_b[HALF_W-1:0]};

  // One 17x17 signed multiplier shared by all four steps
  assign int_result = mulh_a * mulh_b + acc_q;
  assign int_shift  = int_result >>> HALF_W;

  ////////////////////
  // High-word FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    acc_d   = acc_q;
    if (mulh_active) begin
      case (state_q)
        ALBL: begin
          // Only the carry out of the low product matters
          acc_d   = int_shift[ACC_W-1:0];
          state_d = ALBH;
        end
        ALBH: begin
          // First cross product kept unshifted
          // Its low bits still carry into the second cross product
          acc_d   = int_result[ACC_W-1:0];
          state_d = AHBL;
        end
        AHBL: begin
          // Both cross products summed, now drop the fractional half
          acc_d   = int_shift[ACC_W-1:0];
          state_d = AHBH;
        end
        AHBH: begin
          // Hold result until downstream takes it
          if (ex_ready_i) begin
            acc_d   = '0;
            state_d = ALBL;
          end
        end
        default: begin
          acc_d   = '0;
          state_d = ALBL;
        end
      endcase
    end else begin
      // MUL or idle keeps the accumulator cleared
      acc_d   = '0;
      state_d = ALBL;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ALBL;
      acc_q   <= '0;
    end else begin
      state_q <= state_d;
      acc_q   <= acc_d;
    end
  end

  ////////////////////
  // Result
  ////////////////////

  // MUL is done at once, MULH family only in the last step
  assign ready = op.enable & ((op.operator == MUL_M32) | (state_q == AHBH));

  assign op.ready    = ready;
  assign res_valid_o = ready;

  // In AHBH the adder output is the high word of the product
  assign res_data_o = (op.operator == MUL_M32) ? mul_low : int_result[XLEN-1:0];

endmodule

/* hdl/mul_unit_top.sv */
// RV32M multiply unit top; one operation in flight, results held while ex_ready_i is low, no division
module mul_unit_top (
  input  logic                     clk,
  input  logic                     arst_n_i,

  // Request side
  input  logic                     req_valid_i,
  input  mul_pkg::mul_funct_e      req_funct_i,
  input  logic [mul_pkg::XLEN-1:0] req_op_a_i,
  input  logic [mul_pkg::XLEN-1:0] req_op_b_i,
  output logic                     req_ready_o,

  // Result side
  input  logic                     ex_ready_i,
  output logic                     res_valid_o,
  output logic [mul_pkg::XLEN-1:0] res_data_o
);

  ////////////////////
  // Operation link
  ////////////////////

  // Decoded operation from issue buffer to core
  mul_op_if op_if ();

  ////////////////////
  // Issue buffer
  ////////////////////

  // Accepts requests and holds operands for the core
  mul_issue issue0 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_funct_i (req_funct_i),
    .req_op_a_i  (req_op_a_i),
    .req_op_b_i  (req_op_b_i),
    .ex_ready_i  (ex_ready_i),
    .req_ready_o (req_ready_o),
    .op          (op_if.issue)
  );

  ////////////////////
  // Multiplier core
  ////////////////////

  // Result is held by the core under back-pressure
  mul_core core0 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .ex_ready_i  (ex_ready_i),
    .op          (op_if.core),
    .res_valid_o (res_valid_o),
    .res_data_o  (res_data_o)
  );

endmodule

/* verification/mul_unit_checker.sv */
// Passive monitor on the top-level ports only; it sees the handshakes, not the core state or operands
module mul_unit_checker (
  input logic                     clk,
  input logic                     arst_n_i,
  input logic                     req_valid_i,
  input mul_pkg::mul_funct_e      req_funct_i,
  input logic [mul_pkg::XLEN-1:0] req_op_a_i,
  input logic [mul_pkg::XLEN-1:0] req_op_b_i,
  input logic                     req_ready_i,
  input logic                     ex_ready_i,
  input logic                     res_valid_i,
  input logic [mul_pkg::XLEN-1:0] res_data_i
);

  import mul_pkg::*;

  // Running count, read by the testbench for the closing report
  int unsigned     violation_cnt = 0;

  // Stall flags from the previous edge
  logic            req_stall_q;
  logic            res_stall_q;

  // Values seen at the previous edge
  mul_funct_e      funct_q;
  logic [XLEN-1:0] op_a_q;
  logic [XLEN-1:0] op_b_q;
  logic [XLEN-1:0] res_data_q;

  task automatic report_violation(input string what);
    violation_cnt++;
    $display("ERR %0t: checker: %s", $time, what);
  endtask

  ////////////////////
  // Stability checks
  ////////////////////

  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_stall_q <= 1'b0;
      res_stall_q <= 1'b0;
    end else begin
      // Stalled result must stay put until taken
      if (res_stall_q) begin
        if (!res_valid_i) begin
          report_violation("result withdrawn before ex_ready_i");
        end else if (res_data_i !== res_data_q) begin
          report_violation("result data changed while stalled");
        end
      end
      // Pending request held until accepted
      if (req_stall_q) begin
        if (!req_valid_i) begin
          report_violation("request withdrawn before acceptance");
        end else if (req_funct_i !== funct_q || req_op_a_i !== op_a_q ||
                     req_op_b_i !== op_b_q) begin
          report_violation("request changed before acceptance");
        end
      end
      // Slot stays busy under back-pressure
      if (res_valid_i && !ex_ready_i && req_ready_i) begin
        report_violation("req_ready_o high while result stalled");
      end
      req_stall_q <= req_valid_i & ~req_ready_i;
      res_stall_q <= res_valid_i & ~ex_ready_i;
      funct_q     <= req_funct_i;
      op_a_q      <= req_op_a_i;
      op_b_q      <= req_op_b_i;
      res_data_q  <= res_data_i;
    end
  end

endmodule

/* verification/tb_mul_unit.sv */
// Self-checking random testbench; latency checks assume ex_ready_i high and one request in flight
module tb_mul_unit;

  import mul_pkg::*;

  localparam int          NUM_REQ     = 2000;
  localparam int          TIMEOUT_CYC = NUM_REQ * 12 + 100;
  localparam int unsigned SEED        = 32'h7081_a362;

  logic                clk;
  logic                arst_n_i;
  logic                req_valid_i;
  mul_funct_e          req_funct_i;
  logic [XLEN-1:0]     req_op_a_i;
  logic [XLEN-1:0]     req_op_b_i;
  logic                ex_ready_i;
  logic                req_ready_o;
  logic                res_valid_o;
  logic [XLEN-1:0]     res_data_o;

  // Model queue entry is {funct, op_a, op_b}
  logic [2*XLEN+1:0]   pending_q[$];
  logic [2*XLEN+1:0]   head;
  int                  error_cnt  = 0;
  int                  result_cnt = 0;
  int                  cycle_cnt  = 0;

  mul_unit_top dut0 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_funct_i (req_funct_i),
    .req_op_a_i  (req_op_a_i),
    .req_op_b_i  (req_op_b_i),
    .req_ready_o (req_ready_o),
    .ex_ready_i  (ex_ready_i),
    .res_valid_o (res_valid_o),
    .res_data_o  (res_data_o)
  );

  mul_unit_checker chk0 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_funct_i (req_funct_i),
    .req_op_a_i  (req_op_a_i),
    .req_op_b_i  (req_op_b_i),
    .req_ready_i (req_ready_o),
    .ex_ready_i  (ex_ready_i),
    .res_valid_i (res_valid_o),
    .res_data_i  (res_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      error_cnt++;
      $display("ERR %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // Reference from 64-bit arithmetic on extended operands
  function automatic logic [XLEN-1:0] model_result(input mul_funct_e funct,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
    logic        sign_a;
    logic        sign_b;
    logic [63:0] prod;
    // A signed unless MULHU, B signed only for MULH, MUL uses the signed product
    sign_a = (funct != FUNCT_MULHU);
    sign_b = (funct == FUNCT_MULH) || (funct == FUNCT_MUL);
    prod   = {{32{sign_a & a[31]}}, a} * {{32{sign_b & b[31]}}, b};
    if (funct == FUNCT_MUL) begin
      return prod[31:0];
    end else begin
      return prod[63:32];
    end
  endfunction

  // One in eight operands is an extreme value
  function automatic logic [XLEN-1:0] random_operand();
    logic [31:0] pick;
    pick = $urandom;
    if (pick[2:0] == 3'd0) begin
      case ($urandom % 3)
        0:       return 32'h0000_0000;
        1:       return 32'hFFFF_FFFF;
        default: return 32'h8000_0000;
      endcase
    end
    return $urandom;
  endfunction

  task automatic drive_request(input mul_funct_e funct, input logic [XLEN-1:0] a,
                               input logic [XLEN-1:0] b);
    req_valid_i <= 1'b1;
    req_funct_i <= funct;
    req_op_a_i  <= a;
    req_op_b_i  <= b;
  endtask

  // Edges from request transfer to the first edge that sees res_valid_o
  task automatic run_latency_case(input mul_funct_e funct, input logic [XLEN-1:0] a,
                                  input logic [XLEN-1:0] b, input int exp_cycles,
                                  input string what);
    int cycles;
    drive_request(funct, a, b);
    @(posedge clk);
    while (!req_ready_o) @(posedge clk);
    req_valid_i <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!res_valid_o && cycles < 20);
    check_value(64'(cycles), 64'(exp_cycles), what);
  endtask

  ////////////////////
  // Scoreboard
  ////////////////////

  always @(posedge clk) begin
    if (arst_n_i) begin
      // Pop before push so the oldest request owns this result
      if (res_valid_o && ex_ready_i) begin
        result_cnt++;
        if (pending_q.size() == 0) begin
          error_cnt++;
          $display("A result arrived at time %0t with no request outstanding", $time);
        end else begin
          head = pending_q.pop_front();
          check_value(64'(res_data_o),
                      64'(model_result(mul_funct_e'(head[65:64]), head[63:32], head[31:0])),
                      "result data");
        end
      end
      if (req_valid_i && req_ready_o) begin
        pending_q.push_back({req_funct_i, req_op_a_i, req_op_b_i});
      end
    end
  end

  // Hang guard
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("The run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int unsigned sent;
    int          drain_cyc;
    logic        pending;
    logic [31:0] rnd;
    void'($urandom(SEED));
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_funct_i = FUNCT_MUL;
    req_op_a_i  = '0;
    req_op_b_i  = '0;
    ex_ready_i  = 1'b0;
    repeat (3) @(posedge clk);
    arst_n_i   <= 1'b1;
    ex_ready_i <= 1'b1;
    @(posedge clk);
    // Idle state straight out of reset
    check_value(64'(req_ready_o), 64'd1, "req_ready_o after reset");
    check_value(64'(res_valid_o), 64'd0, "res_valid_o after reset");
    // Directed latency pair
    run_latency_case(FUNCT_MUL, 32'h8000_0000, 32'hFFFF_FFFF, 1, "MUL latency");
    run_latency_case(FUNCT_MULH, 32'h8000_0000, 32'h8000_0000, 4, "MULH latency");
    // Random phase keeps each request up until taken
    sent    = 0;
    pending = 1'b0;
    while (sent < NUM_REQ) begin
      @(posedge clk);
      if (req_valid_i && req_ready_o) begin
        sent++;
        pending = 1'b0;
      end
      rnd = $urandom;
      if (!pending && sent < NUM_REQ && (rnd % 10) < 7) begin
        rnd = $urandom;
        drive_request(mul_funct_e'(rnd[1:0]), random_operand(), random_operand());
        pending = 1'b1;
      end else if (!pending) begin
        req_valid_i <= 1'b0;
      end
      ex_ready_i <= (($urandom % 10) < 7);
    end
    req_valid_i <= 1'b0;
    ex_ready_i  <= 1'b1;
    // Drain what is still in flight, at most one high-word operation
    repeat (2) @(posedge clk);
    drain_cyc = 0;
    while (pending_q.size() != 0 && drain_cyc < 16) begin
      @(posedge clk);
      drain_cyc++;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_value(64'(pending_q.size()), 64'd0, "requests without a result");
    check_value(64'(result_cnt), 64'(NUM_REQ + 2), "result count");
    $display("Errors: %0d, checker violations: %0d", error_cnt, chk0.violation_cnt);
    if (error_cnt == 0 && chk0.violation_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
hdl/mul_pkg.sv
hdl/mul_op_if.sv
hdl/mul_issue.sv
hdl/mul_core.sv
hdl/mul_unit_top.sv
verification/mul_unit_checker.sv
verification/tb_mul_unit.sv

/* Makefile */
TOP = tb_mul_unit

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
